/* rtl/msg_pkg.sv */
package msg_pkg;

  // ************************************************************
  // Stream word
  // ************************************************************

  // Host stream word width
  localparam int MSG_WIDTH = 32;

  typedef logic [MSG_WIDTH-1:0] msg_t;

  // All ones marks the end of a stream
  localparam msg_t EOS_WORD = '1;

  // ************************************************************
  // FIFO sizing
  // ************************************************************

  // Ingress holds host writes, egress holds host reads
  localparam int WR_FIFO_DEPTH = 16;
  localparam int RD_FIFO_DEPTH = 16;

  // Free entries left when almost_full rises
  localparam int AF_MARGIN = 2;

  // Occupancy must reach the full depth, so one extra count
  localparam int MAX_FIFO_DEPTH =
    (WR_FIFO_DEPTH > RD_FIFO_DEPTH) ? WR_FIFO_DEPTH : RD_FIFO_DEPTH;
  localparam int LEVEL_WIDTH = $clog2(MAX_FIFO_DEPTH + 1);

  typedef logic [LEVEL_WIDTH-1:0] fifo_level_t;

endpackage

/* rtl/msg_fifo_if.sv */
`timescale 1ns/10ps

interface msg_fifo_if;

  import msg_pkg::*;

  // Producer side
  logic push;
  msg_t push_data;

  // Consumer side
  logic pop;

  // FIFO status, head is valid while empty is low
  msg_t head;
  logic empty;
  logic almost_full;
  logic overflow;

  // The FIFO itself
  modport store (
    input  push,
    input  push_data,
    input  pop,
    output head,
    output empty,
    output almost_full,
    output overflow
  );

  // Writer into the FIFO
  modport fill (
    output push,
    output push_data,
    input  empty,
    input  almost_full,
    input  overflow
  );

  // Reader out of the FIFO
  modport drain (
    output pop,
    input  head,
    input  empty
  );

endinterface

/* rtl/msg_fifo.sv */
`timescale 1ns/10ps

module msg_fifo #(
  parameter int DEPTH = msg_pkg::WR_FIFO_DEPTH
) (
  input logic       bus_clk,
  input logic       rst,
  msg_fifo_if.store port
);

  import msg_pkg::*;

  localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // Occupancy thresholds
  localparam fifo_level_t FULL_LEVEL = fifo_level_t'(DEPTH);
  localparam fifo_level_t AF_LEVEL   = fifo_level_t'(DEPTH - AF_MARGIN);

  // Last valid pointer value before wrapping
  localparam logic [PTR_WIDTH-1:0] LAST_PTR = PTR_WIDTH'(DEPTH - 1);

  msg_t                 mem [DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  fifo_level_t          level;
  logic                 full;
  logic                 do_push;
  logic                 do_pop;
  logic                 overflow_q;

  function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
    logic [PTR_WIDTH-1:0] nxt;
    if (ptr == LAST_PTR) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  // ************************************************************
  // Accept rules
  // ************************************************************

  assign full = (level == FULL_LEVEL);

  // Push to a full buffer is lost
  assign do_push = port.push && !full;
  // Pop while empty does nothing
  assign do_pop  = port.pop && (level != '0);

  // ************************************************************
  // Storage and pointers
  // ************************************************************

  always_ff @(posedge bus_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= port.push_data;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  // Sticky until reset
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      overflow_q <= 1'b0;
    end else if (port.push && full) begin
      overflow_q <= 1'b1;
    end
  end

  // ************************************************************
  // Status
  // ************************************************************

  // First word fall through
  assign port.head        = mem[rd_ptr];
  assign port.empty       = (level == '0);
  assign port.almost_full = (level >= AF_LEVEL);
  assign port.overflow    = overflow_q;

endmodule

/* rtl/msg_relay.sv */
`timescale 1ns/10ps

module msg_relay (
  input  logic      bus_clk,
  input  logic      rst,
  input  logic      rd_open,
  msg_fifo_if.drain src,
  msg_fifo_if.fill  dst,
  output logic      rd_eof
);

  import msg_pkg::*;

  logic take;
  logic keep;
  logic hold_valid;
  msg_t hold_data;
  logic eos_push;
  logic eos_seen;

  // ************************************************************
  // Ingress side
  // ************************************************************

  // Drain whenever a word waits and egress has room.
  // This runs even with the read stream closed.
  assign take    = !src.empty && !dst.almost_full;
  assign src.pop = take;

  // Closed stream throws the word away
  assign keep = take && rd_open;

  // ************************************************************
  // Hold stage
  // ************************************************************

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      hold_valid <= 1'b0;
    end else begin
      hold_valid <= keep;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (keep) begin
      hold_data <= src.head;
    end
  end

  // Held word goes to egress on the next edge
  assign dst.push      = hold_valid;
  assign dst.push_data = hold_data;

  // ************************************************************
  // End of stream
  // ************************************************************

  assign eos_push = hold_valid && (hold_data == EOS_WORD);

  always_ff @(posedge bus_clk) begin
    if (rst || !rd_open) begin
      eos_seen <= 1'b0;
    end else if (eos_push) begin
      eos_seen <= 1'b1;
    end
  end

  // Only once everything up to the marker has been read out
  assign rd_eof = eos_seen && dst.empty;

endmodule

/* rtl/msg_bridge_top.sv */
`timescale 1ns/10ps

module msg_bridge_top (
  input  logic          bus_clk,
  input  logic          rst,

  // Host write stream
  input  logic          wr_wren,
  input  msg_pkg::msg_t wr_data,
  output logic          wr_full,
  output logic          wr_overflow,

  // Host read stream
  input  logic          rd_rden,
  input  logic          rd_open,
  output msg_pkg::msg_t rd_data,
  output logic          rd_empty,
  output logic          rd_eof
);

  import msg_pkg::*;

  msg_fifo_if ingress_if ();
  msg_fifo_if egress_if ();

  // ************************************************************
  // Host port mapping
  // ************************************************************

  // Write stream fills ingress
  assign ingress_if.push      = wr_wren;
  assign ingress_if.push_data = wr_data;

  // Host backs off early, at almost full
  assign wr_full     = ingress_if.almost_full;
  assign wr_overflow = ingress_if.overflow;

  // Read stream drains egress
  assign egress_if.pop = rd_rden;
  assign rd_data       = egress_if.head;
  assign rd_empty      = egress_if.empty;

  // ************************************************************
  // Datapath
  // ************************************************************

  msg_fifo #(
    .DEPTH (WR_FIFO_DEPTH)
  ) u_ingress_fifo (
    .bus_clk (bus_clk),
    .rst     (rst),
    .port    (ingress_if.store)
  );

  msg_relay u_relay (
    .bus_clk (bus_clk),
    .rst     (rst),
    .rd_open (rd_open),
    .src     (ingress_if.drain),
    .dst     (egress_if.fill),
    .rd_eof  (rd_eof)
  );

  // Egress overflow is left unread since the relay
  // stops at almost full
  msg_fifo #(
    .DEPTH (RD_FIFO_DEPTH)
  ) u_egress_fifo (
    .bus_clk (bus_clk),
    .rst     (rst),
    .port    (egress_if.store)
  );

endmodule

/* tb/tb_msg_bridge.sv */
`timescale 1ns/10ps

module tb_msg_bridge;

  import msg_pkg::*;

  localparam string VECTOR_FILE     = "tb/msg_vectors.txt";
  localparam int    RESET_CYCLES    = 10;
  localparam int    READ_WAIT       = 64;
  localparam int    SETTLE_CYCLES   = 4;
  localparam int    DRAIN_IDLE      = 8;
  localparam int    CYCLES_PER_LINE = 100;

  logic bus_clk = 1'b0;
  logic rst;
  logic wr_wren;
  msg_t wr_data;
  logic wr_full;
  logic wr_overflow;
  logic rd_rden;
  logic rd_open;
  msg_t rd_data;
  logic rd_empty;
  logic rd_eof;

  // Parsed vector lines
  byte   op_q[$];
  string arg_q[$];
  int    watch_cycles;
  logic  watch_armed = 1'b0;

  // Words expected on the read stream, and the last flood
  msg_t  model_q[$];
  msg_t  flood_q[$];
  logic  open_level;

  string  cur_test = "";
  int     checks;
  int     errors;
  int     test_checks;
  int     test_errors;
  int     tests_run;
  int     tests_failed;
  integer seed;

  msg_bridge_top u_msg_bridge_top (
    .bus_clk     (bus_clk),
    .rst         (rst),
    .wr_wren     (wr_wren),
    .wr_data     (wr_data),
    .wr_full     (wr_full),
    .wr_overflow (wr_overflow),
    .rd_rden     (rd_rden),
    .rd_open     (rd_open),
    .rd_data     (rd_data),
    .rd_empty    (rd_empty),
    .rd_eof      (rd_eof)
  );

  always #2 bus_clk = ~bus_clk;

  // ************************************************************
  // Bookkeeping
  // ************************************************************

  task automatic compare_word(input string what, input msg_t expected, input msg_t actual);
    checks++;
    test_checks++;
    if (actual !== expected) begin
      errors++;
      test_errors++;
      $display("ERROR test %s, %s: expected %h, actual %h", cur_test, what, expected, actual);
    end
  endtask

  task automatic report_failure(input string text);
    errors++;
    test_errors++;
    $display("test %s: %s", cur_test, text);
  endtask

  task automatic finish_test();
    if (cur_test != "") begin
      tests_run++;
      if (test_errors != 0) begin
        tests_failed++;
      end
      $display("test %s finished: %0d checks, %0d errors", cur_test, test_checks, test_errors);
    end
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic start_test(input string name);
    finish_test();
    cur_test = name;
  endtask

  // Whole file read up front so the watchdog knows the run length
  task automatic load_vectors(output bit ok);
    int    fd;
    int    n;
    int    lines;
    int    flood_total;
    string line;
    string op_s;
    string arg_s;
    msg_t  value;
    ok = 1'b0;
    lines = 0;
    flood_total = 0;
    fd = $fopen(VECTOR_FILE, "r");
    if (fd == 0) begin
      $display("could not open the vector file %s", VECTOR_FILE);
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0) begin
        n = $sscanf(line, "%s %s", op_s, arg_s);
        if (n == 2 && op_s[0] != "#") begin
          op_q.push_back(op_s[0]);
          arg_q.push_back(arg_s);
          lines++;
          if (op_s[0] == "F") begin
            n = $sscanf(arg_s, "%h", value);
            flood_total += int'(value);
          end
        end
      end
    end
    $fclose(fd);
    watch_cycles = RESET_CYCLES + lines * CYCLES_PER_LINE + flood_total;
    ok = 1'b1;
  endtask

  // ************************************************************
  // Stream operations
  // ************************************************************

  task automatic write_word(input msg_t value);
    @(posedge bus_clk);
    wr_wren <= 1'b1;
    wr_data <= value;
    @(posedge bus_clk);
    wr_wren <= 1'b0;
    if (open_level) begin
      model_q.push_back(value);
    end
  endtask

  task automatic pop_word();
    @(posedge bus_clk);
    rd_rden <= 1'b1;
    @(posedge bus_clk);
    rd_rden <= 1'b0;
  endtask

  task automatic read_word(input msg_t expected);
    int   waited;
    msg_t actual;
    msg_t modeled;
    waited = 0;
    @(negedge bus_clk);
    while (rd_empty && waited < READ_WAIT) begin
      @(negedge bus_clk);
      waited++;
    end
    if (rd_empty) begin
      report_failure($sformatf("no word arrived on the read stream within %0d cycles",
                               READ_WAIT));
    end else begin
      actual = rd_data;
      compare_word("read word", expected, actual);
      if (model_q.size() == 0) begin
        report_failure("a word came out although none was written with the stream open");
      end else begin
        modeled = model_q.pop_front();
        compare_word("model word", modeled, actual);
      end
      pop_word();
    end
  endtask

  // Extra cycles let words already in ingress pass the relay
  task automatic set_open(input logic level);
    @(posedge bus_clk);
    rd_open <= level;
    open_level = level;
    repeat (SETTLE_CYCLES) @(posedge bus_clk);
  endtask

  // Words still in flight reach egress before the flag is sampled
  task automatic expect_eof(input logic level);
    repeat (SETTLE_CYCLES) @(posedge bus_clk);
    @(negedge bus_clk);
    compare_word("rd_eof", msg_t'(level), msg_t'(rd_eof));
    if (level) begin
      compare_word("rd_empty", msg_t'(1'b1), msg_t'(rd_empty));
    end
  endtask

  // Writes every cycle regardless of wr_full, then drains
  task automatic flood_words(input int count);
    int   idx;
    int   idle;
    msg_t value;
    msg_t actual;
    flood_q.delete();
    for (idx = 0; idx < count; idx++) begin
      value = $random(seed);
      flood_q.push_back(value);
      @(posedge bus_clk);
      wr_wren <= 1'b1;
      wr_data <= value;
    end
    @(posedge bus_clk);
    wr_wren <= 1'b0;
    repeat (SETTLE_CYCLES) @(posedge bus_clk);
    @(negedge bus_clk);
    compare_word("wr_full", msg_t'(1'b1), msg_t'(wr_full));
    compare_word("wr_overflow", msg_t'(1'b1), msg_t'(wr_overflow));

    // Whatever survived must be the start of the flood, in order
    idx = 0;
    idle = 0;
    while (idle < DRAIN_IDLE) begin
      if (rd_empty) begin
        idle++;
        @(negedge bus_clk);
      end else begin
        idle = 0;
        actual = rd_data;
        if (idx < flood_q.size()) begin
          compare_word($sformatf("flood word %0d", idx), flood_q[idx], actual);
        end else begin
          report_failure("more words came out than were flooded");
        end
        idx++;
        pop_word();
        @(negedge bus_clk);
      end
    end
    if (idx == 0) begin
      report_failure("no flooded word came out of the read stream");
    end
  endtask

  // ************************************************************
  // Sequence
  // ************************************************************

  task automatic check_reset_state();
    start_test("reset_state");
    @(negedge bus_clk);
    compare_word("rd_empty", msg_t'(1'b1), msg_t'(rd_empty));
    compare_word("wr_full", msg_t'(1'b0), msg_t'(wr_full));
    compare_word("wr_overflow", msg_t'(1'b0), msg_t'(wr_overflow));
    compare_word("rd_eof", msg_t'(1'b0), msg_t'(rd_eof));
  endtask

  task automatic run_vectors();
    int    i;
    int    n;
    byte   op;
    string arg;
    msg_t  value;
    for (i = 0; i < op_q.size(); i++) begin
      op = op_q[i];
      arg = arg_q[i];
      value = '0;
      n = 1;
      if (op != "T") begin
        n = $sscanf(arg, "%h", value);
      end
      if (n != 1) begin
        report_failure($sformatf("vector line %0d has no readable hex value", i));
      end else begin
        case (op)
          "T":     start_test(arg);
          "W":     write_word(value);
          "R":     read_word(value);
          "O":     set_open(value[0]);
          "F":     flood_words(int'(value));
          "E":     expect_eof(value[0]);
          default: report_failure($sformatf("unknown vector operation %c", op));
        endcase
      end
    end
  endtask

  initial begin
    bit loaded;
    seed = 819;
    checks = 0;
    errors = 0;
    test_checks = 0;
    test_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    rst = 1'b1;
    wr_wren = 1'b0;
    wr_data = '0;
    rd_rden = 1'b0;
    rd_open = 1'b0;
    open_level = 1'b0;

    load_vectors(loaded);
    if (loaded) begin
      watch_armed = 1'b1;
      repeat (RESET_CYCLES) @(posedge bus_clk);
      rst <= 1'b0;
      check_reset_state();
      run_vectors();
      finish_test();
    end else begin
      errors++;
    end

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (watch_armed);
    repeat (watch_cycles) @(posedge bus_clk);
    $display("watchdog expired: the run did not finish within %0d cycles", watch_cycles);
    $display("TEST FAIL");
    $finish;
  end

endmodule

/* sim.f */
rtl/msg_pkg.sv
rtl/msg_fifo_if.sv
rtl/msg_fifo.sv
rtl/msg_relay.sv
rtl/msg_bridge_top.sv
tb/tb_msg_bridge.sv

/* Makefile */
# Verilator build and run for the message bridge

VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
LINTFLAGS = --lint-only --timing
TOP       = tb_msg_bridge
FILELIST  = sim.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the testbench prints the pass line
run: build
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* tb/msg_vectors.txt */
# op value: T test name, W write word, R expected read word, O rd_open level,
# F flood word count, E expected rd_eof level (all values in hex)
T order
O 1
W 00000001
W 12345678
W deadbeef
W 0000ffff
W a5a5a5a5
R 00000001
R 12345678
R deadbeef
R 0000ffff
R a5a5a5a5
E 0
T discard
O 0
W 11111111
W 22222222
W 33333333
O 1
W 44444444
W 55555555
R 44444444
R 55555555
E 0
T end_of_stream
W 0badf00d
W 7ffffffe
W ffffffff
E 0
R 0badf00d
R 7ffffffe
R ffffffff
E 1
O 0
E 0
T back_pressure
O 1
F 40
